// ==== ppu_timing_pkg.sv ====
`default_nettype none

package ppu_timing_pkg;

    // one line is 341 pixel clocks, cycles 0 to 340
    localparam logic [8:0] cycles_per_line = 9'd341;
    localparam logic [8:0] last_cycle      = 9'd340;

    // lines 0 to 239 are drawn, 261 is the pre-render line
    localparam logic [8:0] visible_lines   = 9'd240;
    localparam logic [8:0] prerender_line  = 9'd261;

    // vblank flag rises at the end of line 240
    localparam logic [8:0] vblank_line     = 9'd240;
    // and falls at the end of line 260
    localparam logic [8:0] vblank_end_line = 9'd260;

    // first two tiles of the next line are fetched here
    localparam logic [8:0] prefetch_first  = 9'd321;
    localparam logic [8:0] prefetch_last   = 9'd336;

    // current raster position, registered in the counter
    typedef struct packed {
        logic [8:0] scanline;
        logic [8:0] cycle;
    } raster_pos_t;

endpackage

`default_nettype wire

// ==== ppu_bus_pkg.sv ====
`default_nettype none

package ppu_bus_pkg;

    // cpu register map, ain values
    localparam logic [2:0] reg_ctrl   = 3'd0;
    localparam logic [2:0] reg_mask   = 3'd1;
    localparam logic [2:0] reg_status = 3'd2;
    localparam logic [2:0] reg_addr   = 3'd6;
    localparam logic [2:0] reg_data   = 3'd7;

    // upper address bits of the 3F00 palette page
    localparam logic [5:0] palette_page = 6'h3f;

    // fixed fields of the nametable and attribute addresses
    localparam logic [1:0] nt_prefix   = 2'b10;
    localparam logic [3:0] attr_marker = 4'b1111;

    typedef struct packed {
        logic [2:0] ain;
        logic [7:0] din;
        logic       read;
        logic       write;
    } cpu_bus_t;

    // the control bits the background path actually uses
    typedef struct packed {
        logic       nmi_enable;
        logic       bg_table;
        logic       increment32;
        logic [1:0] nt_select;
        logic       render_enable;
    } ppu_ctrl_t;

    typedef struct packed {
        logic [13:0] addr;
        logic        read;
        logic        write;
    } vram_req_t;

    typedef struct packed {
        logic       en;
        logic [4:0] index;
        logic [5:0] data;
    } palette_wr_t;

    typedef struct packed {
        logic [7:0] pattern_lo;
        logic [7:0] pattern_hi;
        logic [1:0] attr;
        logic       load;
    } tile_word_t;

    // 0010 nn rrrrr ccccc
    typedef struct packed {
        logic [1:0] prefix;
        logic [1:0] nt_select;
        logic [4:0] row;
        logic [4:0] column;
    } vram_nt_view_t;

    // 0010 nn 1111 yyy xxx
    typedef struct packed {
        logic [1:0] prefix;
        logic [1:0] nt_select;
        logic [3:0] marker;
        logic [2:0] row_group;
        logic [2:0] col_group;
    } vram_attr_view_t;

    // 0 t tttttttt p fff
    typedef struct packed {
        logic       zero;
        logic       table_sel;
        logic [7:0] tile;
        logic       plane;
        logic [2:0] fine_row;
    } vram_pat_view_t;

    typedef union packed {
        vram_nt_view_t   nt;
        vram_attr_view_t attr;
        vram_pat_view_t  pat;
    } vram_addr_u;

endpackage

`default_nettype wire

// ==== ppu_raster_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_raster_counter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        is_vblank,
    input  ppu_bus_pkg::ppu_ctrl_t      ctrl,
    output ppu_timing_pkg::raster_pos_t pos,
    output logic                        vblank_set,
    output logic                        frame_end_clear
);
    import ppu_timing_pkg::*;

    logic odd_frame;
    logic short_line;
    logic line_end;

    // pre-render line drops its last cycle on odd frames while drawing
    assign short_line = odd_frame && pos.scanline == prerender_line &&
                        !is_vblank && ctrl.render_enable;

    assign line_end = short_line ? (pos.cycle == last_cycle - 9'd1) :
                                   (pos.cycle == last_cycle);

    // single-cycle events, on the clk that closes the line
    assign vblank_set      = line_end && pos.scanline == vblank_line;
    assign frame_end_clear = line_end && pos.scanline == vblank_end_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            pos       <= '0;
            odd_frame <= 1'b0;
        end else begin
            if (line_end) begin
                pos.cycle <= '0;
                // 261 wraps back to the first visible line
                if (pos.scanline == prerender_line) begin
                    pos.scanline <= '0;
                end else begin
                    pos.scanline <= pos.scanline + 9'd1;
                end
            end else begin
                pos.cycle <= pos.cycle + 9'd1;
            end
            // parity flips where vblank ends, so line 261 belongs to the new frame
            if (frame_end_clear) begin
                odd_frame <= !odd_frame;
            end
        end
    end

    // line end must always catch the counter
    assert property (@(posedge clk) disable iff (reset) pos.cycle < cycles_per_line)
        else $error("raster cycle ran past the end of the line");

endmodule

`default_nettype wire

// ==== ppu_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_registers (
    input  logic                     clk,
    input  logic                     reset,
    input  ppu_bus_pkg::cpu_bus_t    cpu,
    input  logic                     vblank_set,
    input  logic                     frame_end_clear,
    output ppu_bus_pkg::ppu_ctrl_t   ctrl,
    output logic                     is_vblank,
    output logic                     nmi,
    output logic [7:0]               dout,
    output ppu_bus_pkg::vram_req_t   cpu_access,
    output logic [7:0]               vram_dout,
    output ppu_bus_pkg::palette_wr_t pal_wr
);
    import ppu_bus_pkg::*;

    logic        toggle;
    logic [13:0] vram_addr;
    logic        status_read;
    logic        data_access;
    logic        data_write;
    logic        pal_hit;
    logic        pal_skip;

    assign status_read = cpu.read && cpu.ain == reg_status;
    assign data_access = (cpu.read || cpu.write) && cpu.ain == reg_data;
    assign data_write  = cpu.write && cpu.ain == reg_data;

    // 3F00 page goes to palette RAM, never out to VRAM
    assign pal_hit  = vram_addr[13:8] == palette_page;
    // entries 4, 8, C, 14, 18, 1C are dropped
    assign pal_skip = vram_addr[3:2] != 2'b00 && vram_addr[1:0] == 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl      <= '0;
            toggle    <= 1'b0;
            vram_addr <= '0;
        end else begin
            if (cpu.write && cpu.ain == reg_ctrl) begin
                ctrl.nmi_enable  <= cpu.din[7];
                ctrl.bg_table    <= cpu.din[4];
                ctrl.increment32 <= cpu.din[2];
                ctrl.nt_select   <= cpu.din[1:0];
            end
            // drawing is on if either bg or sprite enable is set
            if (cpu.write && cpu.ain == reg_mask) begin
                ctrl.render_enable <= |cpu.din[4:3];
            end
            // high byte first, then low byte
            if (cpu.write && cpu.ain == reg_addr) begin
                if (!toggle) begin
                    vram_addr[13:8] <= cpu.din[5:0];
                end else begin
                    vram_addr[7:0] <= cpu.din;
                end
                toggle <= !toggle;
            end
            if (data_access) begin
                vram_addr <= vram_addr + (ctrl.increment32 ? 14'd32 : 14'd1);
            end
            if (status_read) begin
                toggle <= 1'b0;
            end
        end
    end

    // a status read wins over a set landing on the same clk
    always_ff @(posedge clk) begin
        if (reset) begin
            is_vblank <= 1'b1;
        end else if (status_read || frame_end_clear) begin
            is_vblank <= 1'b0;
        end else if (vblank_set) begin
            is_vblank <= 1'b1;
        end
    end

    assign nmi  = is_vblank && ctrl.nmi_enable;
    assign dout = status_read ? {is_vblank, 7'd0} : 8'd0;

    always_comb begin
        cpu_access.addr  = vram_addr;
        cpu_access.read  = data_access && !cpu.write;
        cpu_access.write = data_write && !pal_hit;
        pal_wr.en        = data_write && pal_hit && !pal_skip;
        pal_wr.index     = vram_addr[4:0];
        pal_wr.data      = cpu.din[5:0];
    end

    assign vram_dout = cpu.din;

    assert property (@(posedge clk) disable iff (reset) !(pal_wr.en && cpu_access.write))
        else $error("data write sent to both palette and VRAM");

endmodule

`default_nettype wire

// ==== ppu_tile_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_tile_fetch (
    input  logic                        clk,
    input  logic                        reset,
    input  ppu_timing_pkg::raster_pos_t pos,
    input  ppu_bus_pkg::ppu_ctrl_t      ctrl,
    input  ppu_bus_pkg::vram_req_t      cpu_access,
    input  logic [7:0]                  vram_din,
    output logic [13:0]                 vram_a,
    output logic                        vram_r,
    output logic                        vram_w,
    output ppu_bus_pkg::tile_word_t     tile
);
    import ppu_timing_pkg::*;
    import ppu_bus_pkg::*;

    logic       fetch_active;
    logic       fetch_window;
    logic       fetch_strobe;
    logic       cpu_busy;
    logic [8:0] stage_cycle;
    logic [1:0] stage;
    logic [8:0] fetch_line;
    logic [4:0] col;
    logic [4:0] tile_col;
    logic [7:0] nt_latch;
    logic [1:0] attr_latch;
    logic [7:0] pattern_lo_latch;
    logic [2:0] quad_shift;
    vram_addr_u fetch_addr;

    assign fetch_active = ctrl.render_enable &&
                          (pos.scanline < visible_lines || pos.scanline == prerender_line);
    assign fetch_window = (pos.cycle >= 9'd1 && pos.cycle <= 9'd256) ||
                          (pos.cycle >= prefetch_first && pos.cycle <= prefetch_last);
    // address goes out on the odd cycle and is held through the even one
    assign fetch_strobe = fetch_active && fetch_window && pos.cycle[0];
    assign cpu_busy     = cpu_access.read || cpu_access.write;

    // 0: nametable, 1: attribute, 2: pattern low, 3: pattern high
    assign stage_cycle = pos.cycle - 9'd1;
    assign stage       = stage_cycle[2:1];

    // prefetch works on the line that comes next
    assign fetch_line = (pos.cycle < prefetch_first) ? pos.scanline :
                        (pos.scanline == prerender_line) ? 9'd0 : pos.scanline + 9'd1;

    // tile column, two prefetch steps leave it at 2 for the drawn line
    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;
        end else if (pos.cycle == prefetch_first - 9'd1) begin
            col <= '0;
        end else if (fetch_active && fetch_window && pos.cycle[2:0] == 3'd3) begin
            col <= col + 5'd1;
        end
    end

    // quadrant inside the attribute byte, 2 bits per 2x2 tile block
    assign quad_shift = {fetch_line[4], tile_col[1], 1'b0};

    always_ff @(posedge clk) begin
        if (fetch_active && fetch_window) begin
            case (pos.cycle[2:0])
                3'd2: begin
                    nt_latch <= vram_din;
                    // column of the tile in flight, col steps before the attribute lands
                    tile_col <= col;
                end
                3'd4: attr_latch <= vram_din[quad_shift +: 2];
                3'd6: pattern_lo_latch <= vram_din;
                default: ;
            endcase
        end
    end

    always_comb begin
        fetch_addr = '0;
        case (stage)
            2'd0: begin
                fetch_addr.nt.prefix    = nt_prefix;
                fetch_addr.nt.nt_select = ctrl.nt_select;
                fetch_addr.nt.row       = fetch_line[7:3];
                fetch_addr.nt.column    = col;
            end
            2'd1: begin
                fetch_addr.attr.prefix    = nt_prefix;
                fetch_addr.attr.nt_select = ctrl.nt_select;
                fetch_addr.attr.marker    = attr_marker;
                fetch_addr.attr.row_group = fetch_line[7:5];
                fetch_addr.attr.col_group = tile_col[4:2];
            end
            default: begin
                fetch_addr.pat.zero      = 1'b0;
                fetch_addr.pat.table_sel = ctrl.bg_table;
                fetch_addr.pat.tile      = nt_latch;
                // stage 2 is plane 0, stage 3 is plane 1
                fetch_addr.pat.plane     = stage[0];
                fetch_addr.pat.fine_row  = fetch_line[2:0];
            end
        endcase
    end

    // cpu data-port access takes the bus over a background fetch
    assign vram_a = cpu_busy ? cpu_access.addr : fetch_addr;
    assign vram_r = cpu_access.read || (fetch_strobe && !cpu_busy);
    assign vram_w = cpu_access.write;

    // high plane goes straight from the bus into the shifter on the load cycle
    always_comb begin
        tile.pattern_lo = pattern_lo_latch;
        tile.pattern_hi = vram_din;
        tile.attr       = attr_latch;
        tile.load       = fetch_active && fetch_window && pos.cycle[2:0] == 3'd0;
    end

    assert property (@(posedge clk) disable iff (reset) !(vram_r && vram_w))
        else $error("vram read and write strobed together");

endmodule

`default_nettype wire

// ==== ppu_bg_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_bg_shifter (
    input  logic                        clk,
    input  logic                        reset,
    input  ppu_timing_pkg::raster_pos_t pos,
    input  ppu_bus_pkg::tile_word_t     tile,
    output logic [3:0]                  bg_pixel
);
    import ppu_timing_pkg::*;

    logic [15:0] pat_lo_sr;
    logic [15:0] pat_hi_sr;
    logic [7:0]  attr_lo_sr;
    logic [7:0]  attr_hi_sr;
    logic [1:0]  attr_next;
    logic        shift_en;

    assign shift_en = pos.cycle < prefetch_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            pat_lo_sr  <= '0;
            pat_hi_sr  <= '0;
            attr_lo_sr <= '0;
            attr_hi_sr <= '0;
            attr_next  <= '0;
        end else begin
            if (shift_en) begin
                pat_lo_sr[14:0] <= pat_lo_sr[15:1];
                pat_hi_sr[14:0] <= pat_hi_sr[15:1];
                // attribute bits feed in from the latch, one per pixel
                attr_lo_sr <= {attr_next[0], attr_lo_sr[7:1]};
                attr_hi_sr <= {attr_next[1], attr_hi_sr[7:1]};
            end
            // leftmost pixel of the tile is its msb, so reverse into bit 8 first
            if (tile.load) begin
                pat_lo_sr[15:8] <= {<<{tile.pattern_lo}};
                pat_hi_sr[15:8] <= {<<{tile.pattern_hi}};
                attr_next       <= tile.attr;
            end
        end
    end

    // palette group in the upper bits, pattern colour in the lower
    assign bg_pixel = {attr_hi_sr[0], attr_lo_sr[0], pat_hi_sr[0], pat_lo_sr[0]};

endmodule

`default_nettype wire

// ==== ppu_palette.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_palette (
    input  logic                     clk,
    input  ppu_bus_pkg::ppu_ctrl_t   ctrl,
    input  ppu_bus_pkg::palette_wr_t pal_wr,
    input  logic [3:0]               bg_pixel,
    output logic [5:0]               color
);

    // 32 entries of 6-bit colour codes
    logic [5:0] pal_ram [0:31];
    logic [4:0] rd_index;

    // skipped entries are already filtered out of pal_wr.en
    always_ff @(posedge clk) begin
        if (pal_wr.en) begin
            pal_ram[pal_wr.index] <= pal_wr.data;
        end
    end

    // backdrop entry while drawing is off
    assign rd_index = ctrl.render_enable ? {1'b0, bg_pixel} : 5'd0;
    assign color    = pal_ram[rd_index];

endmodule

`default_nettype wire

// ==== ppu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_top (
    input  logic                        clk,
    input  logic                        reset,
    input  ppu_bus_pkg::cpu_bus_t       cpu,
    input  logic [7:0]                  vram_din,
    output logic [7:0]                  dout,
    output logic                        nmi,
    output logic                        vram_r,
    output logic                        vram_w,
    output logic [13:0]                 vram_a,
    output logic [7:0]                  vram_dout,
    output ppu_timing_pkg::raster_pos_t pos,
    output logic [5:0]                  color
);
    import ppu_bus_pkg::*;

    ppu_ctrl_t   ctrl;
    logic        is_vblank;
    logic        vblank_set;
    logic        frame_end_clear;
    vram_req_t   cpu_access;
    palette_wr_t pal_wr;
    tile_word_t  tile;
    logic [3:0]  bg_pixel;

    ppu_raster_counter u_raster_counter (
        .clk             (clk),
        .reset           (reset),
        .is_vblank       (is_vblank),
        .ctrl            (ctrl),
        .pos             (pos),
        .vblank_set      (vblank_set),
        .frame_end_clear (frame_end_clear)
    );

    ppu_registers u_registers (
        .clk             (clk),
        .reset           (reset),
        .cpu             (cpu),
        .vblank_set      (vblank_set),
        .frame_end_clear (frame_end_clear),
        .ctrl            (ctrl),
        .is_vblank       (is_vblank),
        .nmi             (nmi),
        .dout            (dout),
        .cpu_access      (cpu_access),
        .vram_dout       (vram_dout),
        .pal_wr          (pal_wr)
    );

    ppu_tile_fetch u_tile_fetch (
        .clk        (clk),
        .reset      (reset),
        .pos        (pos),
        .ctrl       (ctrl),
        .cpu_access (cpu_access),
        .vram_din   (vram_din),
        .vram_a     (vram_a),
        .vram_r     (vram_r),
        .vram_w     (vram_w),
        .tile       (tile)
    );

    ppu_bg_shifter u_bg_shifter (
        .clk      (clk),
        .reset    (reset),
        .pos      (pos),
        .tile     (tile),
        .bg_pixel (bg_pixel)
    );

    ppu_palette u_palette (
        .clk      (clk),
        .ctrl     (ctrl),
        .pal_wr   (pal_wr),
        .bg_pixel (bg_pixel),
        .color    (color)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns pixel clock, first rising edge at 5 ns
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  logic                        clk,
    input  logic                        reset,
    input  ppu_bus_pkg::cpu_bus_t       cpu,
    input  logic [1:0]                  bg_attr,
    input  logic [7:0]                  dout,
    input  logic                        nmi,
    input  logic                        vram_r,
    input  logic                        vram_w,
    input  logic [13:0]                 vram_a,
    input  logic [7:0]                  vram_dout,
    input  ppu_timing_pkg::raster_pos_t pos,
    input  logic [5:0]                  color,
    output int                          error_count
);
    import ppu_timing_pkg::*;
    import ppu_bus_pkg::*;

    // reference state, always the value the DUT holds in the current cycle
    logic [8:0]  m_line;
    logic [8:0]  m_cycle;
    logic        m_odd;
    logic        m_vblank;
    logic        m_nmi_en;
    logic        m_inc32;
    logic        m_render;
    logic        m_toggle;
    logic [13:0] m_addr;
    logic [5:0]  m_pal [0:31];
    logic [31:0] m_pal_known;
    int          render_lines;
    logic        first_check;

    // palette entries that ignore CPU writes
    function automatic logic skipped_entry(input logic [4:0] idx);
        return idx == 5'h04 || idx == 5'h08 || idx == 5'h0c ||
               idx == 5'h14 || idx == 5'h18 || idx == 5'h1c;
    endfunction

    task automatic report(input string msg);
        error_count++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic reset_model();
        m_line       = '0;
        m_cycle      = '0;
        m_odd        = 1'b0;
        m_vblank     = 1'b1;
        m_nmi_en     = 1'b0;
        m_inc32      = 1'b0;
        m_render     = 1'b0;
        m_toggle     = 1'b0;
        m_addr       = '0;
        render_lines = 0;
        first_check  = 1'b1;
    endtask

    task automatic check_outputs();
        logic [7:0] exp_dout;
        logic [4:0] pix;
        if (pos.scanline !== m_line || pos.cycle !== m_cycle) begin
            report($sformatf("pos line %0d cycle %0d, expected line %0d cycle %0d",
                             pos.scanline, pos.cycle, m_line, m_cycle));
        end
        if (nmi !== (m_vblank && m_nmi_en)) begin
            report($sformatf("nmi %b, expected %b", nmi, m_vblank && m_nmi_en));
        end
        // status read shows vblank in bit 7, otherwise the bus reads 0
        exp_dout = (cpu.read && cpu.ain == reg_status) ? {m_vblank, 7'd0} : 8'd0;
        if (dout !== exp_dout) begin
            report($sformatf("dout %h, expected %h", dout, exp_dout));
        end
        if (vram_r === 1'b1 && vram_w === 1'b1) begin
            report("vram_r and vram_w high together");
        end
        if (first_check && (vram_r !== 1'b0 || vram_w !== 1'b0)) begin
            report("vram strobe high right after reset");
        end
        first_check = 1'b0;
        // data-port writes, palette page stays inside the chip
        if (cpu.write && cpu.ain == reg_data) begin
            if (m_addr[13:8] == palette_page) begin
                if (vram_w !== 1'b0) begin
                    report($sformatf("palette write to %h reached vram", m_addr));
                end
            end else if (vram_w !== 1'b1 || vram_a !== m_addr || vram_dout !== cpu.din) begin
                report($sformatf("vram write w=%b a=%h d=%h, expected a=%h d=%h",
                                 vram_w, vram_a, vram_dout, m_addr, cpu.din));
            end
        end else if (vram_w !== 1'b0) begin
            report("vram_w without a data-port write");
        end
        // backdrop while drawing is off
        if (!m_render && m_pal_known[0] && color !== m_pal[0]) begin
            report($sformatf("backdrop colour %h, expected %h", color, m_pal[0]));
        end
        // solid tiles after two full lines of drawing
        if (m_render && render_lines >= 2 && m_line >= 9'd1 && m_line <= 9'd239 &&
            m_cycle >= 9'd17 && m_cycle <= 9'd256) begin
            pix = {1'b0, bg_attr, 2'b11};
            if (color !== m_pal[pix]) begin
                report($sformatf("pixel colour %h at line %0d cycle %0d, expected %h",
                                 color, m_line, m_cycle, m_pal[pix]));
            end
        end
    endtask

    // state for the coming rising edge, inputs are stable here
    task automatic advance_model();
        logic stat_rd;
        logic data_acc;
        logic short_line;
        logic line_end;
        stat_rd    = cpu.read && cpu.ain == reg_status;
        data_acc   = (cpu.read || cpu.write) && cpu.ain == reg_data;
        short_line = m_line == prerender_line && m_odd && m_render && !m_vblank;
        line_end   = m_cycle == (short_line ? last_cycle - 9'd1 : last_cycle);
        if (stat_rd || (line_end && m_line == vblank_end_line)) begin
            m_vblank = 1'b0;
        end else if (line_end && m_line == vblank_line) begin
            m_vblank = 1'b1;
        end
        // new frame parity from the pre-render line on
        if (line_end && m_line == vblank_end_line) begin
            m_odd = !m_odd;
        end
        if (line_end) begin
            m_cycle      = '0;
            m_line       = (m_line == prerender_line) ? 9'd0 : m_line + 9'd1;
            render_lines = m_render ? render_lines + 1 : 0;
        end else begin
            m_cycle = m_cycle + 9'd1;
        end
        if (cpu.write) begin
            case (cpu.ain)
                reg_ctrl: begin
                    m_nmi_en = cpu.din[7];
                    m_inc32  = cpu.din[2];
                end
                reg_mask: m_render = cpu.din[3] || cpu.din[4];
                reg_addr: begin
                    if (!m_toggle) begin
                        m_addr[13:8] = cpu.din[5:0];
                    end else begin
                        m_addr[7:0] = cpu.din;
                    end
                    m_toggle = !m_toggle;
                end
                reg_data: begin
                    if (m_addr[13:8] == palette_page && !skipped_entry(m_addr[4:0])) begin
                        m_pal[m_addr[4:0]]       = cpu.din[5:0];
                        m_pal_known[m_addr[4:0]] = 1'b1;
                    end
                end
                default: ;
            endcase
        end
        if (stat_rd) begin
            m_toggle = 1'b0;
        end
        if (data_acc) begin
            m_addr = m_addr + (m_inc32 ? 14'd32 : 14'd1);
        end
    endtask

    // compare at the falling edge, halfway between input changes
    initial begin
        error_count = 0;
        m_pal_known = '0;
        reset_model();
        forever begin
            @(negedge clk);
            if (reset) begin
                reset_model();
            end else begin
                check_outputs();
                advance_model();
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_ppu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ppu;
    import ppu_timing_pkg::*;
    import ppu_bus_pkg::*;

    // three frames of pixel clocks plus the setup writes
    localparam int frame_cycles = 341 * 262;
    localparam int setup_cycles = 4000;
    localparam int timeout_ns   = (3 * frame_cycles + setup_cycles) * 10;

    logic        clk;
    logic        reset;
    cpu_bus_t    cpu;
    logic [7:0]  vram_din;
    logic [7:0]  dout;
    logic        nmi;
    logic        vram_r;
    logic        vram_w;
    logic [13:0] vram_a;
    logic [7:0]  vram_dout;
    raster_pos_t pos;
    logic [5:0]  color;
    logic [1:0]  bg_attr;
    logic [7:0]  bg_tile;
    int          error_count;
    logic [7:0]  vram [0:16383];

    tb_clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    ppu_top dut (
        .clk       (clk),
        .reset     (reset),
        .cpu       (cpu),
        .vram_din  (vram_din),
        .dout      (dout),
        .nmi       (nmi),
        .vram_r    (vram_r),
        .vram_w    (vram_w),
        .vram_a    (vram_a),
        .vram_dout (vram_dout),
        .pos       (pos),
        .color     (color)
    );

    tb_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .cpu         (cpu),
        .bg_attr     (bg_attr),
        .dout        (dout),
        .nmi         (nmi),
        .vram_r      (vram_r),
        .vram_w      (vram_w),
        .vram_a      (vram_a),
        .vram_dout   (vram_dout),
        .pos         (pos),
        .color       (color),
        .error_count (error_count)
    );

    // 16 K external VRAM, fill mixes both address bytes
    initial begin
        logic [13:0] a;
        for (int i = 0; i < 16384; i++) begin
            a = 14'(i);
            vram[a] <= a[7:0] ^ {2'b00, a[13:8]};
        end
    end

    // asynchronous read, write on the strobe
    assign vram_din = vram[vram_a];

    always @(posedge clk) begin
        if (vram_w) begin
            vram[vram_a] <= vram_dout;
        end
    end

    // one bus cycle, then one idle cycle
    task automatic bus_op(input logic [2:0] ain, input logic [7:0] din,
                          input logic rd, input logic wr);
        @(posedge clk);
        #1;
        cpu.ain   = ain;
        cpu.din   = din;
        cpu.read  = rd;
        cpu.write = wr;
        @(posedge clk);
        #1;
        cpu = '0;
    endtask

    task automatic write_reg(input logic [2:0] ain, input logic [7:0] din);
        bus_op(ain, din, 1'b0, 1'b1);
    endtask

    task automatic read_status();
        bus_op(reg_status, 8'h00, 1'b1, 1'b0);
    endtask

    // status read puts the address latch back on the high byte
    task automatic set_vram_addr(input logic [13:0] addr);
        read_status();
        write_reg(reg_addr, {2'b00, addr[13:8]});
        write_reg(reg_addr, addr[7:0]);
    endtask

    task automatic fill_vram(input logic [13:0] base, input int count, input logic [7:0] value);
        set_vram_addr(base);
        repeat (count) write_reg(reg_data, value);
    endtask

    task automatic wait_for_nmi();
        do @(negedge clk); while (nmi !== 1'b1);
    endtask

    task automatic wait_for_line(input logic [8:0] line);
        do @(negedge clk); while (pos.scanline != line);
    endtask

    // watchdog
    initial begin
        #(timeout_ns);
        $display("timeout: the run did not finish within %0d ns", timeout_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [13:0] addr;
        int          burst;
        cpu     = '0;
        bg_attr = '0;
        bg_tile = '0;
        void'($urandom(79519));
        @(negedge reset);

        // palette with drawing off, step 1
        write_reg(reg_ctrl, 8'h00);
        set_vram_addr(14'h3f00);
        repeat (32) write_reg(reg_data, 8'($urandom_range(0, 63)));

        // random register traffic, drawing kept off by clearing mask bits 3 and 4
        repeat (60) begin
            r = $urandom;
            case (r[1:0])
                2'd0: write_reg(reg_ctrl, r[15:8]);
                2'd1: write_reg(reg_mask, r[15:8] & 8'he7);
                2'd2: read_status();
                default: begin
                    write_reg(reg_ctrl, r[15:8]);
                    addr = r[29:16];
                    if (addr[13:8] == palette_page) begin
                        addr[13] = 1'b0;
                    end
                    set_vram_addr(addr);
                    burst = int'(r[31:30]) + 1;
                    repeat (burst) write_reg(reg_data, 8'($urandom));
                end
            endcase
        end

        // one solid tile over nametable 0 with one palette group
        write_reg(reg_ctrl, 8'h00);
        r       = $urandom;
        bg_tile = r[7:0];
        bg_attr = r[9:8];
        fill_vram(14'h2000, 960, bg_tile);
        fill_vram({2'b00, bg_tile, 4'h0}, 16, 8'hff);
        fill_vram(14'h23c0, 64, {4{bg_attr}});

        // drawing and nmi on, acknowledge two vblanks
        write_reg(reg_ctrl, 8'h80);
        write_reg(reg_mask, 8'h08);
        repeat (2) begin
            wait_for_nmi();
            repeat (500) @(posedge clk);
            read_status();
            wait_for_line(9'd10);
        end
        wait_for_line(9'd100);

        repeat (2) @(posedge clk);
        $display("run complete: %0d errors", error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
ppu_timing_pkg.sv
ppu_bus_pkg.sv
ppu_raster_counter.sv
ppu_registers.sv
ppu_tile_fetch.sv
ppu_bg_shifter.sv
ppu_palette.sv
ppu_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_ppu.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_ppu
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
